//--- Makefile
TOP = core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

//--- logic/core_consts.svh
// Core-wide constants for the pipeline RTL. Include wherever a size or an opcode is needed.
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

`define CORE_REG_COUNT    32
`define CORE_IMEM_DEPTH   64
`define CORE_IMEM_AW      6          // word index width for the imem

// major opcodes
`define CORE_OPC_LUI      7'b0110111
`define CORE_OPC_OPIMM    7'b0010011
`define CORE_OPC_OP       7'b0110011
`define CORE_OPC_SYSTEM   7'b1110011

`define CORE_INST_EBREAK  32'h00100073

// countdown after the halting instruction leaves decode
`define CORE_DRAIN_CYCLES 2

`endif

//--- logic/core_ctrl.sv
// Run control FSM of the core. Gates fetch and reports the end of each run.
`timescale 1ns/10ps

module core_ctrl (
    input  logic clk,
    input  logic rst_i,
    input  logic start_i,
    input  logic halt_seen_i,
    input  logic halt_illegal_i,
    input  logic drain_done_i,
    output logic fetch_en_o,
    output logic flush_o,
    output logic run_active_o,
    output logic drain_start_o,
    output logic done_o,
    output logic illegal_o
);
    import core_pkg::*;

    run_state_e state_q;
    run_state_e state_d;
    logic       start_ok;

    assign start_ok = start_i && (state_q == IDLE || state_q == HALT);

    // first fetch goes out in the start cycle itself
    assign fetch_en_o    = start_ok || (state_q == RUN && !halt_seen_i);
    assign flush_o       = (state_q == RUN) && halt_seen_i;
    assign drain_start_o = flush_o;
    assign run_active_o  = (state_q == RUN) || (state_q == DRAIN);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE, HALT: if (start_ok) state_d = RUN;
            RUN:        if (halt_seen_i) state_d = DRAIN;
            DRAIN:      if (drain_done_i) state_d = HALT;
            default:    state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q   <= IDLE;
            done_o    <= 1'b0;
            illegal_o <= 1'b0;
        end else begin
            state_q <= state_d;
            done_o  <= (state_q == DRAIN) && drain_done_i;
            if (start_ok) begin
                illegal_o <= 1'b0;
            end else if (flush_o) begin
                illegal_o <= halt_illegal_i;    // held through halt
            end
        end
    end

    // decode only holds instructions once a start has gone out
    a_no_halt_in_idle: assert property (@(posedge clk) disable iff (rst_i)
        halt_seen_i |-> state_q != IDLE);

endmodule

//--- logic/core_pkg.sv
// Shared types of the core. Modules import it in their bodies and use scoped names in ports.
package core_pkg;

    typedef logic [31:0] word_t;      // register value, immediate, alu result
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] pc_t;        // byte address with the low bits always zero

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT,
        ALU_PASS_B                    // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN,
        HALT
    } run_state_e;

endpackage

//--- logic/core_top.sv
// Top level of the four-stage core. Connects run control, counters, pipeline stages and register file.
`timescale 1ns/10ps
`include "core_consts.svh"

module core_top (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     load_we_i,
    input  logic [`CORE_IMEM_AW-1:0] load_addr_i,
    input  core_pkg::word_t          load_data_i,
    input  logic                     start_i,
    output logic                     retire_valid_o,
    output core_pkg::pc_t            retire_pc_o,
    output core_pkg::reg_addr_t      retire_rd_o,
    output logic                     retire_we_o,
    output core_pkg::word_t          retire_wdata_o,
    output logic                     done_o,
    output logic                     illegal_o,
    output core_pkg::word_t          instret_o,
    output core_pkg::word_t          cycles_o
);
    import core_pkg::*;

    logic      fetch_en;
    logic      flush;
    logic      run_active;
    logic      drain_start;
    logic      drain_done;
    logic      halt_seen;
    logic      halt_illegal;
    logic      if_valid;
    pc_t       if_pc;
    word_t     if_inst;
    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    logic      id_valid;
    pc_t       id_pc;
    alu_op_e   id_op;
    word_t     id_a;
    word_t     id_b;
    reg_addr_t id_rd;
    logic      id_we;
    word_t     ex_result;

    core_ctrl i_core_ctrl (
        .clk(clk), .rst_i(rst_i), .start_i(start_i),
        .halt_seen_i(halt_seen), .halt_illegal_i(halt_illegal), .drain_done_i(drain_done),
        .fetch_en_o(fetch_en), .flush_o(flush), .run_active_o(run_active),
        .drain_start_o(drain_start), .done_o(done_o), .illegal_o(illegal_o)
    );

    cycle_timer i_cycle_timer (
        .clk(clk), .rst_i(rst_i), .start_i(start_i),
        .run_active_i(run_active), .drain_start_i(drain_start), .retire_i(retire_valid_o),
        .drain_done_o(drain_done), .cycles_o(cycles_o), .instret_o(instret_o)
    );

    fetch_stage i_fetch_stage (
        .clk(clk), .rst_i(rst_i),
        .load_we_i(load_we_i), .load_addr_i(load_addr_i), .load_data_i(load_data_i),
        .fetch_en_i(fetch_en), .flush_i(flush),
        .if_valid_o(if_valid), .if_pc_o(if_pc), .if_inst_o(if_inst)
    );

    decode_stage i_decode_stage (
        .clk(clk), .rst_i(rst_i), .flush_i(flush),
        .if_valid_i(if_valid), .if_pc_i(if_pc), .if_inst_i(if_inst),
        .rf_rdata1_i(rf_rdata1), .rf_rdata2_i(rf_rdata2),
        .ex_we_i(id_we), .ex_rd_i(id_rd), .ex_result_i(ex_result),   // execute bypass
        .wb_we_i(retire_we_o), .wb_rd_i(retire_rd_o), .wb_wdata_i(retire_wdata_o),
        .rf_raddr1_o(rf_raddr1), .rf_raddr2_o(rf_raddr2),
        .halt_seen_o(halt_seen), .halt_illegal_o(halt_illegal),
        .id_valid_o(id_valid), .id_pc_o(id_pc), .id_op_o(id_op),
        .id_a_o(id_a), .id_b_o(id_b), .id_rd_o(id_rd), .id_we_o(id_we)
    );

    reg_file i_reg_file (
        .clk(clk), .rst_i(rst_i),
        .we_i(retire_we_o), .waddr_i(retire_rd_o), .wdata_i(retire_wdata_o),
        .raddr1_i(rf_raddr1), .raddr2_i(rf_raddr2),
        .rdata1_o(rf_rdata1), .rdata2_o(rf_rdata2)
    );

    exec_stage i_exec_stage (
        .clk(clk), .rst_i(rst_i),
        .id_valid_i(id_valid), .id_pc_i(id_pc), .id_op_i(id_op),
        .id_a_i(id_a), .id_b_i(id_b), .id_rd_i(id_rd), .id_we_i(id_we),
        .ex_result_o(ex_result),
        .wb_valid_o(retire_valid_o), .wb_pc_o(retire_pc_o), .wb_rd_o(retire_rd_o),
        .wb_we_o(retire_we_o), .wb_wdata_o(retire_wdata_o)
    );

endmodule

//--- logic/cycle_timer.sv
// Run counters of the core. Counts active cycles and retired instructions and times the pipeline drain.
`timescale 1ns/10ps
`include "core_consts.svh"

module cycle_timer (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            start_i,
    input  logic            run_active_i,
    input  logic            drain_start_i,
    input  logic            retire_i,
    output logic            drain_done_o,
    output core_pkg::word_t cycles_o,
    output core_pkg::word_t instret_o
);
    import core_pkg::*;

    typedef logic [$clog2(`CORE_DRAIN_CYCLES+1)-1:0] drain_cnt_t;

    drain_cnt_t drain_cnt;
    logic       drain_busy;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cycles_o  <= '0;
            instret_o <= '0;
        end else if (start_i && !run_active_i) begin
            cycles_o  <= 32'd1;                 // start cycle already fetches
            instret_o <= '0;
        end else begin
            if (run_active_i) cycles_o <= cycles_o + 32'd1;
            if (retire_i) instret_o <= instret_o + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            drain_busy <= 1'b0;
            drain_cnt  <= '0;
        end else if (drain_start_i) begin
            drain_busy <= 1'b1;
            drain_cnt  <= drain_cnt_t'(`CORE_DRAIN_CYCLES);
        end else if (drain_busy) begin
            if (drain_cnt == '0) drain_busy <= 1'b0;
            else drain_cnt <= drain_cnt - 1'b1;
        end
    end

    assign drain_done_o = drain_busy && (drain_cnt == '0);

    // one halt per run
    a_drain_not_restarted: assert property (@(posedge clk) disable iff (rst_i)
        drain_start_i |-> !drain_busy);

endmodule

//--- logic/decode_stage.sv
// Decode stage of the core. Decodes, forwards operands, flags halts and fills the execute register.
`timescale 1ns/10ps
`include "core_consts.svh"

module decode_stage (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                flush_i,
    input  logic                if_valid_i,
    input  core_pkg::pc_t       if_pc_i,
    input  core_pkg::word_t     if_inst_i,
    input  core_pkg::word_t     rf_rdata1_i,
    input  core_pkg::word_t     rf_rdata2_i,
    input  logic                ex_we_i,
    input  core_pkg::reg_addr_t ex_rd_i,
    input  core_pkg::word_t     ex_result_i,
    input  logic                wb_we_i,
    input  core_pkg::reg_addr_t wb_rd_i,
    input  core_pkg::word_t     wb_wdata_i,
    output core_pkg::reg_addr_t rf_raddr1_o,
    output core_pkg::reg_addr_t rf_raddr2_o,
    output logic                halt_seen_o,
    output logic                halt_illegal_o,
    output logic                id_valid_o,
    output core_pkg::pc_t       id_pc_o,
    output core_pkg::alu_op_e   id_op_o,
    output core_pkg::word_t     id_a_o,
    output core_pkg::word_t     id_b_o,
    output core_pkg::reg_addr_t id_rd_o,
    output logic                id_we_o
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_op_e    op_dec;
    logic       we_dec;
    logic       use_imm;
    logic       is_ebreak;
    logic       illegal;
    logic       issue;
    word_t      imm;
    word_t      rs1_val;
    word_t      rs2_val;

    // youngest producer wins
    function automatic word_t fwd(input reg_addr_t rs, input word_t rf_val);
        if (ex_we_i && ex_rd_i == rs && rs != '0) begin
            return ex_result_i;
        end
        if (wb_we_i && wb_rd_i == rs && rs != '0) begin
            return wb_wdata_i;
        end
        return rf_val;
    endfunction

    assign opcode      = if_inst_i[6:0];
    assign funct3      = if_inst_i[14:12];
    assign funct7      = if_inst_i[31:25];
    assign rf_raddr1_o = if_inst_i[19:15];
    assign rf_raddr2_o = if_inst_i[24:20];

    always_comb begin
        op_dec    = ALU_ADD;
        we_dec    = 1'b0;
        use_imm   = 1'b1;
        is_ebreak = 1'b0;
        illegal   = 1'b0;
        imm       = {{20{if_inst_i[31]}}, if_inst_i[31:20]};   // i-type
        case (opcode)
            `CORE_OPC_LUI: begin
                op_dec = ALU_PASS_B;
                we_dec = 1'b1;
                imm    = {if_inst_i[31:12], 12'b0};
            end
            `CORE_OPC_OPIMM: begin
                we_dec = 1'b1;
                case (funct3)
                    3'b000: op_dec = ALU_ADD;
                    3'b100: op_dec = ALU_XOR;
                    3'b110: op_dec = ALU_OR;
                    3'b111: op_dec = ALU_AND;
                    3'b001: begin
                        op_dec  = ALU_SLL;
                        illegal = (funct7 != 7'b0);
                    end
                    3'b101: begin
                        op_dec  = ALU_SRL;
                        illegal = (funct7 != 7'b0);     // srai not supported
                    end
                    default: illegal = 1'b1;
                endcase
            end
            `CORE_OPC_OP: begin
                we_dec  = 1'b1;
                use_imm = 1'b0;
                case ({funct7, funct3})
                    10'b0000000_000: op_dec = ALU_ADD;
                    10'b0100000_000: op_dec = ALU_SUB;
                    10'b0000000_111: op_dec = ALU_AND;
                    10'b0000000_110: op_dec = ALU_OR;
                    10'b0000000_100: op_dec = ALU_XOR;
                    10'b0000000_001: op_dec = ALU_SLL;
                    10'b0000000_101: op_dec = ALU_SRL;
                    10'b0000000_010: op_dec = ALU_SLT;
                    default:         illegal = 1'b1;
                endcase
            end
            `CORE_OPC_SYSTEM: begin
                is_ebreak = (if_inst_i == `CORE_INST_EBREAK);
                illegal   = !is_ebreak;             // ecall and csr ops
            end
            default: illegal = 1'b1;
        endcase
    end

    always_comb begin
        rs1_val = fwd(rf_raddr1_o, rf_rdata1_i);
        rs2_val = fwd(rf_raddr2_o, rf_rdata2_i);
    end

    assign halt_seen_o    = if_valid_i && (is_ebreak || illegal);
    assign halt_illegal_o = if_valid_i && illegal;
    assign issue          = if_valid_i && !is_ebreak && !illegal && !flush_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            id_valid_o <= 1'b0;
            id_we_o    <= 1'b0;
        end else begin
            id_valid_o <= issue;
            id_we_o    <= issue && we_dec;      // qualified for forwarding
        end
    end

    always_ff @(posedge clk) begin
        id_pc_o <= if_pc_i;
        id_op_o <= op_dec;
        id_a_o  <= rs1_val;
        id_b_o  <= use_imm ? imm : rs2_val;
        id_rd_o <= if_inst_i[11:7];
    end

endmodule

//--- logic/exec_stage.sv
// Execute stage of the core. The ALU and the write-back register that feeds the retire trace.
`timescale 1ns/10ps

module exec_stage (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                id_valid_i,
    input  core_pkg::pc_t       id_pc_i,
    input  core_pkg::alu_op_e   id_op_i,
    input  core_pkg::word_t     id_a_i,
    input  core_pkg::word_t     id_b_i,
    input  core_pkg::reg_addr_t id_rd_i,
    input  logic                id_we_i,
    output core_pkg::word_t     ex_result_o,
    output logic                wb_valid_o,
    output core_pkg::pc_t       wb_pc_o,
    output core_pkg::reg_addr_t wb_rd_o,
    output logic                wb_we_o,
    output core_pkg::word_t     wb_wdata_o
);
    import core_pkg::*;

    always_comb begin
        case (id_op_i)
            ALU_ADD:    ex_result_o = id_a_i + id_b_i;
            ALU_SUB:    ex_result_o = id_a_i - id_b_i;
            ALU_AND:    ex_result_o = id_a_i & id_b_i;
            ALU_OR:     ex_result_o = id_a_i | id_b_i;
            ALU_XOR:    ex_result_o = id_a_i ^ id_b_i;
            ALU_SLL:    ex_result_o = id_a_i << id_b_i[4:0];
            ALU_SRL:    ex_result_o = id_a_i >> id_b_i[4:0];
            ALU_SLT:    ex_result_o = {31'b0, $signed(id_a_i) < $signed(id_b_i)};
            ALU_PASS_B: ex_result_o = id_b_i;
            default:    ex_result_o = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
            wb_we_o    <= 1'b0;
        end else begin
            wb_valid_o <= id_valid_i;
            wb_we_o    <= id_valid_i && id_we_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc_o    <= id_pc_i;
        wb_rd_o    <= id_rd_i;
        wb_wdata_o <= ex_result_o;
    end

endmodule

//--- logic/fetch_stage.sv
// Fetch stage of the core. Holds the instruction memory, its load port, the pc and the fetch register.
`timescale 1ns/10ps
`include "core_consts.svh"

module fetch_stage (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           load_we_i,
    input  logic [`CORE_IMEM_AW-1:0]       load_addr_i,
    input  core_pkg::word_t                load_data_i,
    input  logic                           fetch_en_i,
    input  logic                           flush_i,
    output logic                           if_valid_o,
    output core_pkg::pc_t                  if_pc_o,
    output core_pkg::word_t                if_inst_o
);
    import core_pkg::*;

    word_t imem [`CORE_IMEM_DEPTH];
    pc_t   pc_q;

    // memory and fetch payload
    always_ff @(posedge clk) begin
        if (load_we_i && !fetch_en_i) begin
            imem[load_addr_i] <= load_data_i;   // only lands while fetch is stopped
        end
        if (fetch_en_i) begin
            if_inst_o <= imem[pc_q[`CORE_IMEM_AW+1:2]];
            if_pc_o   <= pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            pc_q       <= '0;                   // next start runs from pc 0
            if_valid_o <= 1'b0;
        end else begin
            if_valid_o <= fetch_en_i;
            if (fetch_en_i) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

endmodule

//--- logic/reg_file.sv
// Integer register file of the core. One synchronous write port and two combinational reads.
`timescale 1ns/10ps
`include "core_consts.svh"

module reg_file (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                we_i,
    input  core_pkg::reg_addr_t waddr_i,
    input  core_pkg::word_t     wdata_i,
    input  core_pkg::reg_addr_t raddr1_i,
    input  core_pkg::reg_addr_t raddr2_i,
    output core_pkg::word_t     rdata1_o,
    output core_pkg::word_t     rdata2_o
);
    import core_pkg::*;

    word_t regs [`CORE_REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;           // x0 never written
        end
    end

    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

endmodule

//--- sim.f
+incdir+logic
logic/core_pkg.sv
logic/fetch_stage.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/exec_stage.sv
logic/core_ctrl.sv
logic/cycle_timer.sv
logic/core_top.sv
sim/core_checker.sv
sim/core_tb.sv

//--- sim/core_checker.sv
// Testbench checker for the core. Runs a reference model and compares the retire trace.
`timescale 1ns/10ps
`include "core_consts.svh"

module core_checker (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     load_we_i,
    input  logic [`CORE_IMEM_AW-1:0] load_addr_i,
    input  core_pkg::word_t          load_data_i,
    input  logic                     start_i,
    input  logic                     retire_valid_i,
    input  core_pkg::pc_t            retire_pc_i,
    input  core_pkg::reg_addr_t      retire_rd_i,
    input  logic                     retire_we_i,
    input  core_pkg::word_t          retire_wdata_i,
    input  logic                     done_i,
    input  logic                     illegal_i,
    input  core_pkg::word_t          instret_i,
    input  core_pkg::word_t          cycles_i,
    output int                       err_count_o
);
    import core_pkg::*;

    word_t     prog_mem [`CORE_IMEM_DEPTH];     // copy of what went through the load port
    word_t     model_regs [`CORE_REG_COUNT];    // kept across restarts
    pc_t       exp_pc_q [$];
    reg_addr_t exp_rd_q [$];
    word_t     exp_wdata_q [$];
    int        exp_retires;
    logic      exp_illegal;
    logic      started;
    logic      running;
    longint    cyc;
    longint    start_cyc;
    int        retire_idx;

    // reference semantics of the RV32I subset that return 0 outside it
    function automatic logic model_exec(input word_t inst, output word_t result);
        word_t      a;
        word_t      b;
        word_t      imm;
        logic [2:0] f3;
        logic [6:0] f7;
        a      = model_regs[inst[19:15]];
        b      = model_regs[inst[24:20]];
        imm    = {{20{inst[31]}}, inst[31:20]};
        f3     = inst[14:12];
        f7     = inst[31:25];
        result = '0;
        if (inst[6:0] == `CORE_OPC_LUI) begin
            result = {inst[31:12], 12'h000};
            return 1'b1;
        end
        if (inst[6:0] == `CORE_OPC_OPIMM) begin
            case (f3)
                3'b000:  result = a + imm;
                3'b100:  result = a ^ imm;
                3'b110:  result = a | imm;
                3'b111:  result = a & imm;
                3'b001:  result = a << inst[24:20];
                3'b101:  result = a >> inst[24:20];
                default: return 1'b0;
            endcase
            if ((f3 == 3'b001 || f3 == 3'b101) && f7 != 7'b0) return 1'b0;   // srai and friends
            return 1'b1;
        end
        if (inst[6:0] == `CORE_OPC_OP) begin
            if (f7 == 7'b0100000 && f3 == 3'b000) begin
                result = a - b;
                return 1'b1;
            end
            if (f7 != 7'b0) return 1'b0;
            case (f3)
                3'b000:  result = a + b;
                3'b001:  result = a << b[4:0];
                3'b010:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b100:  result = a ^ b;
                3'b101:  result = a >> b[4:0];
                3'b110:  result = a | b;
                3'b111:  result = a & b;
                default: return 1'b0;                // sltu is not in the subset
            endcase
            return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic clear_model();
        int i;
        for (i = 0; i < `CORE_REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        exp_pc_q.delete();
        exp_rd_q.delete();
        exp_wdata_q.delete();
        started     = 1'b0;
        running     = 1'b0;
        cyc         = 0;
        err_count_o = 0;
    endtask

    // walk the program from pc 0 until ebreak or an unknown encoding
    task automatic run_model();
        word_t inst;
        word_t result;
        int    k;
        exp_pc_q.delete();
        exp_rd_q.delete();
        exp_wdata_q.delete();
        exp_illegal = 1'b0;
        for (k = 0; k < `CORE_IMEM_DEPTH; k++) begin
            inst = prog_mem[k];
            if (inst == `CORE_INST_EBREAK) break;
            if (!model_exec(inst, result)) begin
                exp_illegal = 1'b1;
                break;
            end
            exp_pc_q.push_back(pc_t'(k * 4));
            exp_rd_q.push_back(inst[11:7]);
            exp_wdata_q.push_back(result);          // trace shows the result even for x0
            if (inst[11:7] != 5'd0) model_regs[inst[11:7]] = result;
        end
        exp_retires = exp_pc_q.size();
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
            err_count_o++;
        end
    endtask

    task automatic check_retire();
        if (exp_pc_q.size() == 0) begin
            $display("ERROR at %0t: pc %h retired but the model has no instruction left",
                     $time, retire_pc_i);
            err_count_o++;
            return;
        end
        check_value("retire_pc_o", retire_pc_i, exp_pc_q.pop_front());
        check_value("retire_rd_o", 32'(retire_rd_i), 32'(exp_rd_q.pop_front()));
        check_value("retire_we_o", 32'(retire_we_i), 32'd1);
        check_value("retire_wdata_o", retire_wdata_i, exp_wdata_q.pop_front());
        if (cyc != start_cyc + 3 + retire_idx) begin
            $display("ERROR at %0t: instruction %0d retired %0d cycles after start, not %0d",
                     $time, retire_idx, cyc - start_cyc, retire_idx + 3);
            err_count_o++;
        end
        retire_idx++;
    endtask

    task automatic check_end();
        if (exp_pc_q.size() != 0) begin
            $display("ERROR at %0t: run ended with %0d expected retires missing",
                     $time, exp_pc_q.size());
            err_count_o++;
        end
        check_value("instret_o", instret_i, 32'(exp_retires));
        check_value("cycles_o", cycles_i, 32'(exp_retires + 5));   // two to fill and three to drain
        check_value("illegal_o", 32'(illegal_i), 32'(exp_illegal));
        if (cyc != start_cyc + exp_retires + 5) begin
            $display("ERROR at %0t: done_o came %0d cycles after start, not %0d",
                     $time, cyc - start_cyc, exp_retires + 5);
            err_count_o++;
        end
        running = 1'b0;
    endtask

    always @(posedge clk) begin
        if (rst_i) begin
            clear_model();
        end else begin
            cyc++;
            if (load_we_i && !running) prog_mem[load_addr_i] = load_data_i;
            if (start_i && !running) begin
                run_model();
                started    = 1'b1;
                running    = 1'b1;
                start_cyc  = cyc;
                retire_idx = 0;
            end
            if (!started && (retire_valid_i || done_i || illegal_i)) begin
                $display("ERROR at %0t: core output active before the first start", $time);
                err_count_o++;
            end
            if (retire_valid_i) check_retire();
            if (done_i) check_end();
        end
    end

endmodule

//--- sim/core_tb.sv
// Testbench top for the core. Loads and starts seeded random programs under a cycle limit.
`timescale 1ns/10ps
`include "core_consts.svh"

module core_tb;
    import core_pkg::*;

    localparam int PROG_LEN    = 41;            // 40 instructions and the ebreak
    localparam int CYCLE_LIMIT = (0 + 80) + 3 * (PROG_LEN + 80);

    logic                     clk = 1'b0;
    logic                     rst_i;
    logic                     load_we;
    logic [`CORE_IMEM_AW-1:0] load_addr;
    word_t                    load_data;
    logic                     start;
    logic                     retire_valid;
    pc_t                      retire_pc;
    reg_addr_t                retire_rd;
    logic                     retire_we;
    word_t                    retire_wdata;
    logic                     done;
    logic                     illegal;
    word_t                    instret;
    word_t                    cycles;
    int                       err_count;
    int                       cycle_count = 0;
    int                       tests_run;
    int                       tests_failed;
    int                       last_errors;
    word_t                    prog [PROG_LEN];

    core_top i_core_top (
        .clk(clk), .rst_i(rst_i),
        .load_we_i(load_we), .load_addr_i(load_addr), .load_data_i(load_data),
        .start_i(start),
        .retire_valid_o(retire_valid), .retire_pc_o(retire_pc), .retire_rd_o(retire_rd),
        .retire_we_o(retire_we), .retire_wdata_o(retire_wdata),
        .done_o(done), .illegal_o(illegal), .instret_o(instret), .cycles_o(cycles)
    );

    core_checker i_core_checker (
        .clk(clk), .rst_i(rst_i),
        .load_we_i(load_we), .load_addr_i(load_addr), .load_data_i(load_data),
        .start_i(start),
        .retire_valid_i(retire_valid), .retire_pc_i(retire_pc), .retire_rd_i(retire_rd),
        .retire_we_i(retire_we), .retire_wdata_i(retire_wdata),
        .done_i(done), .illegal_i(illegal), .instret_i(instret), .cycles_i(cycles),
        .err_count_o(err_count)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic word_t random_inst();
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        int unsigned kind;
        rd   = reg_addr_t'($urandom_range(0, 7));   // few registers for lots of forwarding
        rs1  = reg_addr_t'($urandom_range(0, 7));
        rs2  = reg_addr_t'($urandom_range(0, 7));
        kind = $urandom_range(0, 14);
        case (kind)
            0:  return {20'($urandom), rd, `CORE_OPC_LUI};
            1:  return {12'($urandom), rs1, 3'b000, rd, `CORE_OPC_OPIMM};   // addi
            2:  return {12'($urandom), rs1, 3'b100, rd, `CORE_OPC_OPIMM};   // xori
            3:  return {12'($urandom), rs1, 3'b110, rd, `CORE_OPC_OPIMM};   // ori
            4:  return {12'($urandom), rs1, 3'b111, rd, `CORE_OPC_OPIMM};   // andi
            5:  return {7'b0, 5'($urandom), rs1, 3'b001, rd, `CORE_OPC_OPIMM};
            6:  return {7'b0, 5'($urandom), rs1, 3'b101, rd, `CORE_OPC_OPIMM};
            7:  return {7'b0000000, rs2, rs1, 3'b000, rd, `CORE_OPC_OP};    // add
            8:  return {7'b0100000, rs2, rs1, 3'b000, rd, `CORE_OPC_OP};    // sub
            9:  return {7'b0000000, rs2, rs1, 3'b111, rd, `CORE_OPC_OP};
            10: return {7'b0000000, rs2, rs1, 3'b110, rd, `CORE_OPC_OP};
            11: return {7'b0000000, rs2, rs1, 3'b100, rd, `CORE_OPC_OP};
            12: return {7'b0000000, rs2, rs1, 3'b001, rd, `CORE_OPC_OP};
            13: return {7'b0000000, rs2, rs1, 3'b101, rd, `CORE_OPC_OP};
            default: return {7'b0000000, rs2, rs1, 3'b010, rd, `CORE_OPC_OP};   // slt
        endcase
    endfunction

    function automatic word_t illegal_inst();
        case ($urandom_range(0, 2))
            0:       return {25'($urandom), 7'b0000011};                    // load opcode
            1:       return {7'b0100000, 5'd3, 5'd1, 3'b101, 5'd2, `CORE_OPC_OPIMM};
            default: return 32'h00000073;                                   // ecall
        endcase
    endfunction

    // illegal_idx below zero gives a clean program
    task automatic build_program(input int illegal_idx);
        int k;
        for (k = 0; k < PROG_LEN - 1; k++) begin
            prog[k] = random_inst();
        end
        prog[PROG_LEN-1] = `CORE_INST_EBREAK;
        if (illegal_idx >= 0) prog[illegal_idx] = illegal_inst();
    endtask

    task automatic load_program();
        int k;
        for (k = 0; k < PROG_LEN; k++) begin
            @(negedge clk);
            load_we   = 1'b1;
            load_addr = k[`CORE_IMEM_AW-1:0];
            load_data = prog[k];
        end
        @(negedge clk);
        load_we = 1'b0;
    endtask

    task automatic run_program();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!done) begin
            @(negedge clk);
        end
        @(negedge clk);                             // checker has seen the end of run
    endtask

    task automatic finish_test(input string name);
        int new_errors;
        new_errors  = err_count - last_errors;
        last_errors = err_count;
        tests_run++;
        if (new_errors != 0) tests_failed++;
        $display("test %0d %s: %s, %0d errors", tests_run, name,
                 (new_errors == 0) ? "ok" : "failed", new_errors);
    endtask

    initial begin
        void'($urandom(32'h6c83));
        rst_i        = 1'b1;
        load_we      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        start        = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        last_errors  = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;

        repeat (20) @(negedge clk);                 // checker flags any early output
        finish_test("outputs quiet after reset");

        build_program(-1);
        load_program();
        run_program();
        finish_test("random program");

        build_program(int'($urandom_range(0, PROG_LEN - 2)));
        load_program();
        run_program();
        finish_test("illegal encoding halt");

        build_program(-1);                          // registers carry over from before
        load_program();
        run_program();
        finish_test("reload and restart");

        $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
